//--- posit_accum_unit.f
verilog/accum_pkg.sv
verilog/bus_pkg.sv
verilog/value_accumulator.sv
verilog/operand_streamer.sv
verilog/result_writer.sv
verilog/bus_arbiter.sv
verilog/value_memory.sv
verilog/posit_accum_unit.sv
tb/posit_accum_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module posit_accum_unit_tb \
    -f posit_accum_unit.f -o posit_accum_unit_sim \
    && ./obj_dir/posit_accum_unit_sim | tee /dev/stderr | grep -q "^=== PASS ===$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- tb/posit_accum_unit_tb.sv
/*
 * Testbench for the posit accumulation unit with directed runs over the host
 * port and a software model of the truncating sum
 */
`timescale 1ns/1ps

module posit_accum_unit_tb
    import accum_pkg::*;
    import bus_pkg::*;
;

    localparam int ADR_W        = 8;
    localparam int ACK_TIMEOUT  = 50;
    localparam int RUN_TIMEOUT  = 2000;
    localparam logic [FRAC_W-1:0] COARSE = 21'h1FF000;

    logic              clk;
    logic              rst;
    logic              host_cyc;
    logic              host_stb;
    logic              host_we;
    logic [ADR_W-1:0]  host_adr;
    logic [DATA_W-1:0] host_dat_w;
    logic [DATA_W-1:0] host_dat_r;
    logic              host_ack;
    logic              start;
    logic [ADR_W-1:0]  src_adr;
    logic [ADR_W:0]    count;
    logic [ADR_W-1:0]  dst_adr;
    logic              busy;
    logic              done;
    logic              truncated;

    // Mirror of every word the host has written
    logic [DATA_W-1:0] shadow [0:(1<<ADR_W)-1];
    int                err_count;
    int                timeout_count;

    posit_accum_unit #(.ADR_W(ADR_W)) dut_i (
        .clk(clk), .rst(rst),
        .host_cyc(host_cyc), .host_stb(host_stb), .host_we(host_we),
        .host_adr(host_adr), .host_dat_w(host_dat_w),
        .host_dat_r(host_dat_r), .host_ack(host_ack),
        .start(start), .src_adr(src_adr), .count(count), .dst_adr(dst_adr),
        .busy(busy), .done(done), .truncated(truncated)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic value_error(input string what, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        $display("ERR %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        err_count++;
    endtask

    function automatic value_word_u make_value(input bit sgn, input int scale,
                                               input logic [FRAC_W-1:0] frac);
        value_word_u v;
        v.f.sgn      = sgn;
        v.f.scale    = SCALE_W'(scale);
        v.f.fraction = frac;
        v.f.inf      = 1'b0;
        v.f.zero     = 1'b0;
        return v;
    endfunction

    // One addition by the format rules with a flag for ones lost in alignment
    function automatic value_word_u add_model(input value_word_u acc, input value_word_u op,
                                              output bit lost);
        value_word_u hi;
        value_word_u lo;
        value_word_u r;
        longint      hi_m;
        longint      lo_full;
        longint      lo_m;
        longint      s;
        int          diff;
        int          p;
        bit          op_larger;
        lost = 1'b0;
        if (op.f.zero || acc.f.zero)
        begin
            r = op.f.zero ? acc : op;
            r.f.inf = acc.f.inf | op.f.inf;
            return r;
        end
        op_larger = ($signed(op.f.scale) > $signed(acc.f.scale)) ||
                    (op.f.scale == acc.f.scale && op.f.fraction >= acc.f.fraction);
        hi = op_larger ? op : acc;
        lo = op_larger ? acc : op;
        hi_m    = ((longint'(1) << FRAC_W) | longint'(hi.f.fraction)) << GUARD_W;
        lo_full = ((longint'(1) << FRAC_W) | longint'(lo.f.fraction)) << GUARD_W;
        diff    = int'($signed(hi.f.scale)) - int'($signed(lo.f.scale));
        if (diff > 40)
        begin
            lo_m = 0;
            lost = 1'b1;
        end
        else
        begin
            lo_m = lo_full >> diff;
            lost = ((lo_m << diff) != lo_full);
        end
        s = (hi.f.sgn == lo.f.sgn) ? hi_m + lo_m : hi_m - lo_m;
        r.raw   = ZERO_WORD;
        r.f.inf = acc.f.inf | op.f.inf;
        if (s != 0)
        begin
            p = 0;
            for (int i = 0; i < 40; i++)
            begin
                if (s[i])
                    p = i;
            end
            r.f.sgn   = hi.f.sgn;
            r.f.scale = SCALE_W'(int'($signed(hi.f.scale)) + p - (FRAC_W + GUARD_W));
            if (p >= FRAC_W)
                r.f.fraction = FRAC_W'(s >> (p - FRAC_W));
            else
                r.f.fraction = FRAC_W'(s << (FRAC_W - p));
            r.f.zero = 1'b0;
        end
        return r;
    endfunction

    function automatic value_word_u sum_model(input logic [ADR_W-1:0] src, input int n,
                                              output bit any_lost);
        value_word_u acc;
        value_word_u op;
        bit          lost;
        acc.raw  = ZERO_WORD;
        any_lost = 1'b0;
        for (int i = 0; i < n; i++)
        begin
            op.raw   = shadow[ADR_W'(src + i)];
            acc      = add_model(acc, op, lost);
            any_lost = any_lost | lost;
        end
        return acc;
    endfunction

    task automatic host_write(input logic [ADR_W-1:0] a, input logic [DATA_W-1:0] d);
        int n;
        @(posedge clk);
        host_cyc   <= 1'b1;
        host_stb   <= 1'b1;
        host_we    <= 1'b1;
        host_adr   <= a;
        host_dat_w <= d;
        n = 0;
        @(negedge clk);
        while (!host_ack && n < ACK_TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        if (!host_ack)
        begin
            $display("Timeout: host write to address %h was never acknowledged", a);
            timeout_count++;
        end
        shadow[a] = d;
        @(posedge clk);
        host_cyc <= 1'b0;
        host_stb <= 1'b0;
        host_we  <= 1'b0;
    endtask

    task automatic host_read(input logic [ADR_W-1:0] a, output logic [DATA_W-1:0] d);
        int n;
        @(posedge clk);
        host_cyc <= 1'b1;
        host_stb <= 1'b1;
        host_we  <= 1'b0;
        host_adr <= a;
        n = 0;
        @(negedge clk);
        while (!host_ack && n < ACK_TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        if (!host_ack)
        begin
            $display("Timeout: host read from address %h was never acknowledged", a);
            timeout_count++;
        end
        d = host_dat_r;
        @(posedge clk);
        host_cyc <= 1'b0;
        host_stb <= 1'b0;
    endtask

    task automatic pulse_start(input logic [ADR_W-1:0] src, input int n,
                               input logic [ADR_W-1:0] dst);
        @(posedge clk);
        start   <= 1'b1;
        src_adr <= src;
        count   <= (ADR_W+1)'(n);
        dst_adr <= dst;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        @(negedge clk);
        while (!done && n < RUN_TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        if (!done)
        begin
            $display("Timeout: run did not signal done within %0d cycles", RUN_TIMEOUT);
            timeout_count++;
        end
    endtask

    task automatic run_accum(input logic [ADR_W-1:0] src, input int n,
                             input logic [ADR_W-1:0] dst);
        pulse_start(src, n, dst);
        wait_done();
    endtask

    task automatic memory_readback();
        logic [ADR_W-1:0]  a [0:11];
        logic [DATA_W-1:0] d;
        for (int i = 0; i < 12; i++)
        begin
            a[i] = ADR_W'($urandom);
            host_write(a[i], $urandom);
        end
        for (int i = 0; i < 12; i++)
        begin
            host_read(a[i], d);
            if (d !== shadow[a[i]])
                value_error($sformatf("readback at %h", a[i]), d, shadow[a[i]]);
        end
    endtask

    task automatic same_sign_sums();
        logic [ADR_W-1:0]  src;
        logic [ADR_W-1:0]  dst;
        logic [DATA_W-1:0] d;
        value_word_u       exp;
        bit                lost;
        src = ADR_W'(8'h20 + $urandom % 16);
        dst = ADR_W'(8'hC0 + $urandom % 32);
        // Low fraction bits stay clear so alignment loses nothing
        for (int i = 0; i < 16; i++)
            host_write(ADR_W'(src + i),
                       make_value(i >= 8, int'($urandom % 5) - 2, FRAC_W'($urandom) & COARSE));
        for (int k = 0; k < 2; k++)
        begin
            run_accum(ADR_W'(src + 8 * k), 8, dst);
            exp = sum_model(ADR_W'(src + 8 * k), 8, lost);
            host_read(dst, d);
            if (d !== exp.raw)
                value_error($sformatf("same-sign sum %0d", k), d, exp.raw);
            if (truncated !== 1'b0)
                value_error("truncated after same-sign sum", truncated, 0);
        end
    endtask

    task automatic mixed_sign_cancel();
        value_word_u       x;
        value_word_u       y;
        value_word_u       exp;
        logic [DATA_W-1:0] d;
        bit                lost;
        x = make_value(1'b0, 2, FRAC_W'($urandom) & COARSE);
        y = make_value(1'b1, 6, FRAC_W'($urandom) & COARSE);
        host_write(8'h40, x.raw);
        host_write(8'h41, y.raw);
        y.f.sgn = 1'b0;
        x.f.sgn = 1'b1;
        host_write(8'h42, y.raw);
        host_write(8'h43, x.raw);
        // The larger negative operand sets the sign
        run_accum(8'h40, 2, 8'hD0);
        exp = sum_model(8'h40, 2, lost);
        host_read(8'hD0, d);
        if (d !== exp.raw)
            value_error("mixed-sign partial sum", d, exp.raw);
        if (d[VALUE_W-1] !== 1'b1)
            value_error("sign of mixed-sign partial sum", d[VALUE_W-1], 1);
        run_accum(8'h40, 4, 8'hD1);
        exp = sum_model(8'h40, 4, lost);
        host_read(8'hD1, d);
        if (d !== exp.raw)
            value_error("mixed-sign full sum", d, exp.raw);
        if (d !== ZERO_WORD)
            value_error("exact cancellation", d, ZERO_WORD);
    endtask

    task automatic scale_gap_truncation();
        value_word_u       big;
        value_word_u       exp;
        logic [DATA_W-1:0] d;
        bit                lost;
        big = make_value(1'b0, 40, FRAC_W'($urandom));
        host_write(8'h50, big.raw);
        host_write(8'h51, make_value(1'b0, 0, FRAC_W'($urandom)));
        host_write(8'h52, make_value(1'b0, 5, FRAC_W'($urandom) & COARSE));
        host_write(8'h53, make_value(1'b0, 5, FRAC_W'($urandom) & COARSE));
        run_accum(8'h50, 2, 8'hD2);
        host_read(8'hD2, d);
        if (d !== big.raw)
            value_error("sum across a 40-scale gap", d, big.raw);
        if (truncated !== 1'b1)
            value_error("truncated after scale gap", truncated, 1);
        run_accum(8'h52, 2, 8'hD3);
        exp = sum_model(8'h52, 2, lost);
        host_read(8'hD3, d);
        if (d !== exp.raw)
            value_error("sum without gap", d, exp.raw);
        if (truncated !== 1'b0)
            value_error("truncated cleared by next run", truncated, 0);
    endtask

    task automatic infinity_propagation();
        value_word_u       v;
        value_word_u       exp;
        logic [DATA_W-1:0] d;
        bit                lost;
        host_write(8'h60, make_value(1'b0, 1, FRAC_W'($urandom) & COARSE));
        v = make_value(1'b1, 3, FRAC_W'($urandom) & COARSE);
        v.f.inf = 1'b1;
        host_write(8'h61, v.raw);
        host_write(8'h62, make_value(1'b0, 0, FRAC_W'($urandom) & COARSE));
        run_accum(8'h60, 3, 8'hD4);
        exp = sum_model(8'h60, 3, lost);
        host_read(8'hD4, d);
        if (d !== exp.raw)
            value_error("sum with infinity", d, exp.raw);
        if (d[1] !== 1'b1)
            value_error("inf flag of result", d[1], 1);
    endtask

    task automatic count_zero_and_busy();
        value_word_u       exp;
        logic [DATA_W-1:0] d;
        bit                lost;
        int                extra;
        host_write(8'hD5, make_value(1'b1, 7, FRAC_W'($urandom)));
        run_accum(8'h00, 0, 8'hD5);
        host_read(8'hD5, d);
        if (d !== ZERO_WORD)
            value_error("count-zero result", d, ZERO_WORD);
        for (int i = 0; i < 16; i++)
            host_write(ADR_W'(8'h80 + i),
                       make_value($urandom % 2, int'($urandom % 9) - 4, FRAC_W'($urandom)));
        pulse_start(8'h80, 16, 8'hD6);
        repeat (4) @(posedge clk);
        @(negedge clk);
        if (busy !== 1'b1)
            value_error("busy during a long run", busy, 1);
        // A shorter run from other operands lands while busy and must be dropped
        pulse_start(8'h88, 4, 8'hD6);
        wait_done();
        extra = 0;
        repeat (200)
        begin
            @(negedge clk);
            if (done)
                extra++;
        end
        if (extra != 0)
            value_error("done pulses after the run", extra, 0);
        exp = sum_model(8'h80, 16, lost);
        host_read(8'hD6, d);
        if (d !== exp.raw)
            value_error("long run result", d, exp.raw);
        if (truncated !== lost)
            value_error("truncated after long run", truncated, lost);
    endtask

    initial
    begin
        void'($urandom(50249));
        err_count     = 0;
        timeout_count = 0;
        rst        = 1'b1;
        host_cyc   = 1'b0;
        host_stb   = 1'b0;
        host_we    = 1'b0;
        host_adr   = '0;
        host_dat_w = '0;
        start      = 1'b0;
        src_adr    = '0;
        count      = '0;
        dst_adr    = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if ({busy, done, truncated} !== 3'b000)
            value_error("busy, done, truncated after reset", {busy, done, truncated}, 0);

        memory_readback();
        same_sign_sums();
        mixed_sign_cancel();
        scale_gap_truncation();
        infinity_propagation();
        count_zero_and_busy();

        $display("Errors: %0d wrong values, %0d timeouts", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- verilog/accum_pkg.sv
/*
 * Accumulator value format: unpacked posit-style word with sign, signed scale,
 * fraction without hidden bit, infinity and zero flags
 */
package accum_pkg;

    localparam int VALUE_W = 32;
    localparam int SCALE_W = 8;
    localparam int FRAC_W  = 21;
    localparam int GUARD_W = 3;

    typedef struct packed {
        logic                      sgn;
        logic signed [SCALE_W-1:0] scale;
        logic        [FRAC_W-1:0]  fraction;
        logic                      inf;
        logic                      zero;
    } value_fields_t;

    // Same bus word, seen as raw data or as value fields
    typedef union packed {
        logic [VALUE_W-1:0] raw;
        value_fields_t      f;
    } value_word_u;

    localparam logic [VALUE_W-1:0] ZERO_WORD = {{(VALUE_W-1){1'b0}}, 1'b1};

endpackage

//--- verilog/bus_arbiter.sv
/*
 * Fixed-priority Wishbone classic arbiter for host, writer and streamer;
 * the grant moves only while the granted master is idle
 */
`timescale 1ns/1ps

module bus_arbiter
    import bus_pkg::*;
#(
    parameter int ADR_W = 8
)
(
    input  logic              clk,
    input  logic              rst,
    input  logic              host_cyc,
    input  logic              host_stb,
    input  logic              host_we,
    input  logic [ADR_W-1:0]  host_adr,
    input  logic [DATA_W-1:0] host_dat_w,
    output logic [DATA_W-1:0] host_dat_r,
    output logic              host_ack,
    input  logic              wr_cyc,
    input  logic              wr_stb,
    input  logic              wr_we,
    input  logic [ADR_W-1:0]  wr_adr,
    input  logic [DATA_W-1:0] wr_dat_w,
    output logic [DATA_W-1:0] wr_dat_r,
    output logic              wr_ack,
    input  logic              st_cyc,
    input  logic              st_stb,
    input  logic              st_we,
    input  logic [ADR_W-1:0]  st_adr,
    input  logic [DATA_W-1:0] st_dat_w,
    output logic [DATA_W-1:0] st_dat_r,
    output logic              st_ack,
    output logic              mem_cyc,
    output logic              mem_stb,
    output logic              mem_we,
    output logic [ADR_W-1:0]  mem_adr,
    output logic [DATA_W-1:0] mem_dat_w,
    input  logic [DATA_W-1:0] mem_dat_r,
    input  logic              mem_ack
);

    localparam int GNT_W = $clog2(N_MASTERS);

    logic [N_MASTERS-1:0] req;
    logic [GNT_W-1:0]     grant;

    assign req[M_HOST]     = host_cyc;
    assign req[M_WRITER]   = wr_cyc;
    assign req[M_STREAMER] = st_cyc;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            grant <= GNT_W'(M_HOST);
        else if (!req[grant])
        begin
            if (req[M_HOST])
                grant <= GNT_W'(M_HOST);
            else if (req[M_WRITER])
                grant <= GNT_W'(M_WRITER);
            else if (req[M_STREAMER])
                grant <= GNT_W'(M_STREAMER);
        end
    end

    always_comb
    begin
        mem_cyc   = host_cyc;
        mem_stb   = host_stb;
        mem_we    = host_we;
        mem_adr   = host_adr;
        mem_dat_w = host_dat_w;
        if (grant == GNT_W'(M_WRITER))
        begin
            mem_cyc   = wr_cyc;
            mem_stb   = wr_stb;
            mem_we    = wr_we;
            mem_adr   = wr_adr;
            mem_dat_w = wr_dat_w;
        end
        else if (grant == GNT_W'(M_STREAMER))
        begin
            mem_cyc   = st_cyc;
            mem_stb   = st_stb;
            mem_we    = st_we;
            mem_adr   = st_adr;
            mem_dat_w = st_dat_w;
        end
    end

    // Read data is shared, ack picks the owner
    assign host_dat_r = mem_dat_r;
    assign wr_dat_r   = mem_dat_r;
    assign st_dat_r   = mem_dat_r;
    assign host_ack   = mem_ack && (grant == GNT_W'(M_HOST));
    assign wr_ack     = mem_ack && (grant == GNT_W'(M_WRITER));
    assign st_ack     = mem_ack && (grant == GNT_W'(M_STREAMER));

endmodule

//--- verilog/bus_pkg.sv
/*
 * Shared Wishbone definitions: data width and master indices,
 * the index order is also the arbitration priority
 */
package bus_pkg;

    localparam int DATA_W = accum_pkg::VALUE_W;

    localparam int N_MASTERS  = 3;
    localparam int M_HOST     = 0;
    localparam int M_WRITER   = 1;
    localparam int M_STREAMER = 2;

endpackage

//--- verilog/operand_streamer.sv
/*
 * Operand streamer: run sequencer that reads each operand over the bus,
 * feeds it to the accumulator and waits for the sum before the next one
 */
`timescale 1ns/1ps

module operand_streamer
    import accum_pkg::*;
    import bus_pkg::*;
#(
    parameter int ADR_W = 8
)
(
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic [ADR_W-1:0]  src_adr,
    input  logic [ADR_W:0]    count,
    input  logic              write_done,
    output logic              busy,
    output logic              acc_clear,
    output logic              in_valid,
    output value_word_u       in_word,
    output logic              last_done,
    output logic              cyc,
    output logic              stb,
    output logic              we,
    output logic [ADR_W-1:0]  adr,
    output logic [DATA_W-1:0] dat_w,
    input  logic [DATA_W-1:0] dat_r,
    input  logic              ack,
    input  logic              out_valid,
    input  logic              trunc,
    output logic              truncated
);

    localparam logic [2:0] S_IDLE  = 3'd0;
    localparam logic [2:0] S_CLEAR = 3'd1;
    localparam logic [2:0] S_READ  = 3'd2;
    localparam logic [2:0] S_FEED  = 3'd3;
    localparam logic [2:0] S_WAIT  = 3'd4;
    localparam logic [2:0] S_LAST  = 3'd5;
    localparam logic [2:0] S_HOLD  = 3'd6;

    logic [2:0]       state;
    logic [ADR_W-1:0] ptr;
    logic [ADR_W:0]   remaining;
    logic             accept;
    value_word_u      op_q;

    // Busy drops together with write_done, so a new start is taken in that cycle
    assign busy   = (state != S_IDLE) && !write_done;
    assign accept = start && !busy;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state     <= S_IDLE;
            ptr       <= '0;
            remaining <= '0;
            truncated <= 1'b0;
        end
        else if (accept)
        begin
            state     <= S_CLEAR;
            ptr       <= src_adr;
            remaining <= count;
            truncated <= 1'b0;
        end
        else
        begin
            case (state)
                S_CLEAR: state <= (remaining == '0) ? S_LAST : S_READ;
                S_READ:
                    if (ack)
                        state <= S_FEED;
                S_FEED:
                begin
                    state     <= S_WAIT;
                    ptr       <= ptr + 1'b1;
                    remaining <= remaining - 1'b1;
                end
                S_WAIT:
                    if (out_valid)
                    begin
                        truncated <= truncated | trunc;
                        state     <= (remaining == '0) ? S_LAST : S_READ;
                    end
                S_LAST: state <= S_HOLD;
                S_HOLD:
                    if (write_done)
                        state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == S_READ && ack)
            op_q.raw <= dat_r;
    end

    assign acc_clear = (state == S_CLEAR);
    assign in_valid  = (state == S_FEED);
    assign in_word   = op_q;
    assign last_done = (state == S_LAST);

    // Read-only master
    assign cyc   = (state == S_READ);
    assign stb   = (state == S_READ);
    assign we    = 1'b0;
    assign adr   = ptr;
    assign dat_w = '0;

endmodule

//--- verilog/posit_accum_unit.sv
/*
 * Posit accumulation unit with host port, arbiter, shared memory, operand
 * streamer, pipelined accumulator and result writer
 */
`timescale 1ns/1ps

module posit_accum_unit
    import accum_pkg::*;
    import bus_pkg::*;
#(
    parameter int ADR_W = 8
)
(
    input  logic              clk,
    input  logic              rst,
    input  logic              host_cyc,
    input  logic              host_stb,
    input  logic              host_we,
    input  logic [ADR_W-1:0]  host_adr,
    input  logic [DATA_W-1:0] host_dat_w,
    output logic [DATA_W-1:0] host_dat_r,
    output logic              host_ack,
    input  logic              start,
    input  logic [ADR_W-1:0]  src_adr,
    input  logic [ADR_W:0]    count,
    input  logic [ADR_W-1:0]  dst_adr,
    output logic              busy,
    output logic              done,
    output logic              truncated
);

    logic              wr_cyc, wr_stb, wr_we, wr_ack;
    logic [ADR_W-1:0]  wr_adr;
    logic [DATA_W-1:0] wr_dat_w;

    logic              st_cyc, st_stb, st_we, st_ack;
    logic [ADR_W-1:0]  st_adr;
    logic [DATA_W-1:0] st_dat_w, st_dat_r;

    logic              mem_cyc, mem_stb, mem_we, mem_ack;
    logic [ADR_W-1:0]  mem_adr;
    logic [DATA_W-1:0] mem_dat_w, mem_dat_r;

    logic        acc_clear, in_valid, out_valid, trunc;
    logic        last_done, write_done;
    value_word_u in_word, sum_word;

    bus_arbiter #(.ADR_W(ADR_W)) arbiter_i (
        .clk(clk), .rst(rst),
        .host_cyc(host_cyc), .host_stb(host_stb), .host_we(host_we),
        .host_adr(host_adr), .host_dat_w(host_dat_w),
        .host_dat_r(host_dat_r), .host_ack(host_ack),
        .wr_cyc(wr_cyc), .wr_stb(wr_stb), .wr_we(wr_we),
        .wr_adr(wr_adr), .wr_dat_w(wr_dat_w),
        .wr_dat_r(), .wr_ack(wr_ack),
        .st_cyc(st_cyc), .st_stb(st_stb), .st_we(st_we),
        .st_adr(st_adr), .st_dat_w(st_dat_w),
        .st_dat_r(st_dat_r), .st_ack(st_ack),
        .mem_cyc(mem_cyc), .mem_stb(mem_stb), .mem_we(mem_we),
        .mem_adr(mem_adr), .mem_dat_w(mem_dat_w),
        .mem_dat_r(mem_dat_r), .mem_ack(mem_ack)
    );

    value_memory #(.ADR_W(ADR_W)) memory_i (
        .clk(clk), .rst(rst),
        .cyc(mem_cyc), .stb(mem_stb), .we(mem_we),
        .adr(mem_adr), .dat_w(mem_dat_w),
        .dat_r(mem_dat_r), .ack(mem_ack)
    );

    operand_streamer #(.ADR_W(ADR_W)) streamer_i (
        .clk(clk), .rst(rst),
        .start(start), .src_adr(src_adr), .count(count),
        .write_done(write_done), .busy(busy),
        .acc_clear(acc_clear), .in_valid(in_valid), .in_word(in_word),
        .last_done(last_done),
        .cyc(st_cyc), .stb(st_stb), .we(st_we), .adr(st_adr),
        .dat_w(st_dat_w), .dat_r(st_dat_r), .ack(st_ack),
        .out_valid(out_valid), .trunc(trunc), .truncated(truncated)
    );

    value_accumulator accumulator_i (
        .clk(clk), .rst(rst),
        .acc_clear(acc_clear), .in_valid(in_valid), .in_word(in_word),
        .out_valid(out_valid), .sum_word(sum_word), .trunc(trunc)
    );

    result_writer #(.ADR_W(ADR_W)) writer_i (
        .clk(clk), .rst(rst),
        .last_done(last_done), .sum_word(sum_word), .dst_adr(dst_adr),
        .ack(wr_ack),
        .cyc(wr_cyc), .stb(wr_stb), .we(wr_we), .adr(wr_adr),
        .dat_w(wr_dat_w), .write_done(write_done)
    );

    // The writer's completion pulse ends the run
    assign done = write_done;

endmodule

//--- verilog/result_writer.sv
/*
 * Result writer: stores the final sum at the destination address
 * with one Wishbone write
 */
`timescale 1ns/1ps

module result_writer
    import accum_pkg::*;
    import bus_pkg::*;
#(
    parameter int ADR_W = 8
)
(
    input  logic              clk,
    input  logic              rst,
    input  logic              last_done,
    input  value_word_u       sum_word,
    input  logic [ADR_W-1:0]  dst_adr,
    input  logic              ack,
    output logic              cyc,
    output logic              stb,
    output logic              we,
    output logic [ADR_W-1:0]  adr,
    output logic [DATA_W-1:0] dat_w,
    output logic              write_done
);

    logic             active;
    value_word_u      sum_q;
    logic [ADR_W-1:0] adr_q;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            active     <= 1'b0;
            write_done <= 1'b0;
        end
        else
        begin
            write_done <= active & ack;
            if (last_done)
                active <= 1'b1;
            else if (ack)
                active <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (last_done)
        begin
            sum_q <= sum_word;
            adr_q <= dst_adr;
        end
    end

    assign cyc   = active;
    assign stb   = active;
    assign we    = active;
    assign adr   = adr_q;
    assign dat_w = sum_q.raw;

endmodule

//--- verilog/value_accumulator.sv
/*
 * Value accumulator: four-stage order, align, add and normalize pipeline
 * that adds each input word into the accumulator register
 */
`timescale 1ns/1ps

module value_accumulator
    import accum_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        acc_clear,
    input  logic        in_valid,
    input  value_word_u in_word,
    output logic        out_valid,
    output value_word_u sum_word,
    output logic        trunc
);

    // Hidden bit, fraction and guard bits
    localparam int MANT_W = 1 + FRAC_W + GUARD_W;
    localparam int LZ_W   = $clog2(MANT_W + 1);

    value_word_u acc_q;

    value_fields_t a, b, hi0, lo0;
    logic          a_ge_b;

    logic             s1_valid, s1_add, s1_inf;
    value_fields_t    s1_hi, s1_lo;
    logic [SCALE_W:0] s1_diff;
    logic [MANT_W-1:0] lo_mant, lost_mask;

    logic              s2_valid, s2_add, s2_inf, s2_trunc, s2_sgn;
    logic [SCALE_W-1:0] s2_scale;
    logic [MANT_W-1:0] s2_hi_m, s2_lo_m;

    logic               s3_valid, s3_inf, s3_trunc, s3_sgn;
    logic [SCALE_W-1:0] s3_scale;
    logic [MANT_W:0]    s3_sum;

    logic [LZ_W-1:0]         s4_lz;
    logic [MANT_W:0]         s4_norm;
    logic signed [SCALE_W:0] s4_scale;
    value_word_u             s4_word;

    function automatic logic [LZ_W-1:0] lead_zeros(input logic [MANT_W:0] v);
        logic [LZ_W-1:0] n;
        n = LZ_W'(MANT_W);
        for (int i = 0; i <= MANT_W; i++)
        begin
            if (v[i])
                n = LZ_W'(MANT_W - i);
        end
        return n;
    endfunction

    // Stage 1: order by magnitude, a zero always counts as the smaller one
    assign a = in_word.f;
    assign b = acc_q.f;
    assign a_ge_b = b.zero || (!a.zero && ($signed(a.scale) > $signed(b.scale) ||
                    (a.scale == b.scale && a.fraction >= b.fraction)));
    assign hi0 = a_ge_b ? a : b;
    assign lo0 = a_ge_b ? b : a;

    // Stage 2 inputs: anything shifted out of the mantissa frame is lost
    assign lo_mant   = {~s1_lo.zero, s1_lo.fraction, {GUARD_W{1'b0}}};
    assign lost_mask = (s1_diff >= MANT_W) ? {MANT_W{1'b1}} : ~({MANT_W{1'b1}} << s1_diff);

    // Stage 4: put the leading one at the top bit and drop what lies below the fraction
    assign s4_lz    = lead_zeros(s3_sum);
    assign s4_norm  = s3_sum << s4_lz;
    assign s4_scale = $signed({s3_scale[SCALE_W-1], s3_scale}) + 1
                      - $signed({{(SCALE_W+1-LZ_W){1'b0}}, s4_lz});

    always_comb
    begin
        if (s3_sum == '0)
        begin
            s4_word.raw   = ZERO_WORD;
            s4_word.f.inf = s3_inf;
        end
        else
        begin
            s4_word.f.sgn      = s3_sgn;
            s4_word.f.scale    = s4_scale[SCALE_W-1:0];
            s4_word.f.fraction = s4_norm[MANT_W-1 -: FRAC_W];
            s4_word.f.inf      = s3_inf;
            s4_word.f.zero     = 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        s1_hi   <= hi0;
        s1_lo   <= lo0;
        s1_add  <= (a.sgn == b.sgn);
        s1_inf  <= a.inf | b.inf;
        s1_diff <= {hi0.scale[SCALE_W-1], hi0.scale} - {lo0.scale[SCALE_W-1], lo0.scale};

        s2_hi_m  <= {~s1_hi.zero, s1_hi.fraction, {GUARD_W{1'b0}}};
        s2_lo_m  <= lo_mant >> s1_diff;
        s2_trunc <= |(lo_mant & lost_mask);
        s2_add   <= s1_add;
        s2_inf   <= s1_inf;
        s2_sgn   <= s1_hi.sgn;
        s2_scale <= s1_hi.scale;

        // Stage 3: larger magnitude is first, so a difference never goes negative
        if (s2_add)
            s3_sum <= {1'b0, s2_hi_m} + {1'b0, s2_lo_m};
        else
            s3_sum <= {1'b0, s2_hi_m} - {1'b0, s2_lo_m};
        s3_inf   <= s2_inf;
        s3_trunc <= s2_trunc;
        s3_sgn   <= s2_sgn;
        s3_scale <= s2_scale;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            s3_valid  <= 1'b0;
            out_valid <= 1'b0;
            trunc     <= 1'b0;
            acc_q.raw <= ZERO_WORD;
        end
        else
        begin
            s1_valid  <= in_valid;
            s2_valid  <= s1_valid;
            s3_valid  <= s2_valid;
            out_valid <= s3_valid;
            trunc     <= s3_valid & s3_trunc;
            if (acc_clear)
                acc_q.raw <= ZERO_WORD;
            else if (s3_valid)
                acc_q <= s4_word;
        end
    end

    assign sum_word = acc_q;

endmodule

//--- verilog/value_memory.sv
/*
 * Single-port word memory behind a Wishbone classic slave port,
 * access and ack one clock after the request is seen
 */
`timescale 1ns/1ps

module value_memory
    import bus_pkg::*;
#(
    parameter int ADR_W = 8
)
(
    input  logic              clk,
    input  logic              rst,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  logic [ADR_W-1:0]  adr,
    input  logic [DATA_W-1:0] dat_w,
    output logic [DATA_W-1:0] dat_r,
    output logic              ack
);

    logic [DATA_W-1:0] mem [0:(1<<ADR_W)-1];
    logic              req;

    // No new access while ack is high, so each request gets a single ack
    assign req = cyc && stb && !ack;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            ack <= 1'b0;
        else
            ack <= req;
    end

    always_ff @(posedge clk)
    begin
        if (req)
        begin
            if (we)
                mem[adr] <= dat_w;
            dat_r <= mem[adr];
        end
    end

endmodule
